/* include/gemm_defines.svh */
// Widths, lane count, register map and scratchpad size for the GEMM accelerator RTL
`ifndef GEMM_DEFINES_SVH
`define GEMM_DEFINES_SVH

// Datapath widths
`define GEMM_ELEM_W       16
`define GEMM_ARRAY_WIDTH  2
`define GEMM_WORD_W       32
`define GEMM_DIM_W        4

// Scratchpad geometry
`define GEMM_MEM_DEPTH    256
`define GEMM_MEM_AW       8

// APB register map, byte offsets
`define GEMM_APB_AW       12
`define GEMM_REG_CTRL     12'h000
`define GEMM_REG_STATUS   12'h004
`define GEMM_REG_M        12'h008
`define GEMM_REG_K        12'h00C
`define GEMM_REG_XBASE    12'h010
`define GEMM_REG_WBASE    12'h014
`define GEMM_REG_YBASE    12'h018
`define GEMM_REG_ZBASE    12'h01C
`define GEMM_MEM_WINDOW   12'h400

`endif

/* hw/gemm_pkg.sv */
// State and opcode types shared by the GEMM accelerator stages, imported where needed
`default_nettype none

package gemm_pkg;

  // Job controller in the register file
  typedef enum logic [1:0] {
    IDLE = 2'd0,
    RUN  = 2'd1,
    DONE = 2'd2
  } ctrl_state_e;

  // Fetch sequence per row of X
  typedef enum logic [2:0] {
    F_IDLE  = 3'd0,
    F_Y     = 3'd1,
    F_X     = 3'd2,
    F_W     = 3'd3,
    F_STORE = 3'd4
  } fetch_state_e;

  // Opcode that travels with every pipeline read
  typedef enum logic [1:0] {
    OP_LOAD_Y = 2'd0,
    OP_LOAD_X = 2'd1,
    OP_MAC_W  = 2'd2,
    OP_STORE  = 2'd3
  } pipe_op_e;

endpackage : gemm_pkg

`default_nettype wire

/* hw/gemm_apb_regs.sv */
// APB slave that the top level uses for job registers, start and status logic and the scratchpad window
`timescale 1ns/1ns
`default_nettype none
`include "gemm_defines.svh"

module gemm_apb_regs (
  input  wire                          clk_i,
  input  wire                          rst_i,
  input  wire                          psel_i,
  input  wire                          penable_i,
  input  wire                          pwrite_i,
  input  wire  [`GEMM_APB_AW-1:0]      paddr_i,
  input  wire  [`GEMM_WORD_W-1:0]      pwdata_i,
  output logic [`GEMM_WORD_W-1:0]      prdata_o,
  output logic                         pready_o,
  output logic                         pslverr_o,
  input  wire                          job_end_i,
  output logic                         start_o,
  output logic [`GEMM_DIM_W-1:0]       m_o,
  output logic [`GEMM_DIM_W-1:0]       k_o,
  output logic [`GEMM_MEM_AW-1:0]      xbase_o,
  output logic [`GEMM_MEM_AW-1:0]      wbase_o,
  output logic [`GEMM_MEM_AW-1:0]      ybase_o,
  output logic [`GEMM_MEM_AW-1:0]      zbase_o,
  output logic                         busy_o,
  output logic                         done_o,
  output logic                         mem_we_o,
  output logic [`GEMM_MEM_AW-1:0]      mem_addr_o,
  output logic [`GEMM_WORD_W-1:0]      mem_wdata_o,
  input  wire  [`GEMM_WORD_W-1:0]      mem_rdata_i
);
  import gemm_pkg::*;

  ctrl_state_e             state_q;
  logic                    access;
  logic                    reg_hit;
  logic                    win_hit;
  logic                    start_req;
  logic                    err;
  logic                    wr_access;
  logic [`GEMM_APB_AW-1:0] win_off;

  assign access   = psel_i && penable_i;
  assign pready_o = access;
  assign busy_o   = (state_q == RUN);
  assign done_o   = busy_o && job_end_i;

  // Window covers one 32-bit word per scratchpad entry
  assign win_off = paddr_i - `GEMM_MEM_WINDOW;
  assign win_hit = (paddr_i >= `GEMM_MEM_WINDOW) &&
                   (win_off[`GEMM_APB_AW-1:`GEMM_MEM_AW+2] == '0);

  always_comb begin
    case (paddr_i)
      `GEMM_REG_CTRL, `GEMM_REG_STATUS, `GEMM_REG_M, `GEMM_REG_K,
      `GEMM_REG_XBASE, `GEMM_REG_WBASE, `GEMM_REG_YBASE, `GEMM_REG_ZBASE: reg_hit = 1'b1;
      default: reg_hit = 1'b0;
    endcase
  end

  assign start_req = pwrite_i && (paddr_i == `GEMM_REG_CTRL) && pwdata_i[0];

  // Unmapped address, window access while running or a start that cannot run
  assign err = (!reg_hit && !win_hit) ||
               (win_hit && busy_o) ||
               (start_req && (busy_o || (m_o == '0) || (k_o == '0)));

  assign pslverr_o = access && err;
  assign wr_access = access && pwrite_i && !err;
  assign start_o   = wr_access && start_req;

  assign mem_we_o    = wr_access && win_hit;
  assign mem_addr_o  = win_off[`GEMM_MEM_AW+1:2];
  assign mem_wdata_o = pwdata_i;

  always_comb begin
    prdata_o = '0;
    if (psel_i && !pwrite_i && !err) begin
      if (win_hit) begin
        prdata_o = mem_rdata_i;
      end else begin
        // CTRL has no stored bits and reads as zero
        case (paddr_i)
          `GEMM_REG_STATUS: prdata_o = {30'd0, (state_q == DONE), busy_o};
          `GEMM_REG_M:      prdata_o = 32'(m_o);
          `GEMM_REG_K:      prdata_o = 32'(k_o);
          `GEMM_REG_XBASE:  prdata_o = 32'(xbase_o);
          `GEMM_REG_WBASE:  prdata_o = 32'(wbase_o);
          `GEMM_REG_YBASE:  prdata_o = 32'(ybase_o);
          `GEMM_REG_ZBASE:  prdata_o = 32'(zbase_o);
          default:          prdata_o = '0;
        endcase
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q <= IDLE;
      m_o     <= '0;
      k_o     <= '0;
      xbase_o <= '0;
      wbase_o <= '0;
      ybase_o <= '0;
      zbase_o <= '0;
    end else begin
      if (wr_access) begin
        case (paddr_i)
          `GEMM_REG_M:     m_o     <= pwdata_i[`GEMM_DIM_W-1:0];
          `GEMM_REG_K:     k_o     <= pwdata_i[`GEMM_DIM_W-1:0];
          `GEMM_REG_XBASE: xbase_o <= pwdata_i[`GEMM_MEM_AW-1:0];
          `GEMM_REG_WBASE: wbase_o <= pwdata_i[`GEMM_MEM_AW-1:0];
          `GEMM_REG_YBASE: ybase_o <= pwdata_i[`GEMM_MEM_AW-1:0];
          `GEMM_REG_ZBASE: zbase_o <= pwdata_i[`GEMM_MEM_AW-1:0];
          default: ;
        endcase
      end
      case (state_q)
        IDLE, DONE: if (start_o) state_q <= RUN;
        RUN:        if (job_end_i) state_q <= DONE;
        default:    state_q <= IDLE;
      endcase
    end
  end

  // The fetch stage reports a job end only while a job runs
  assert property (@(posedge clk_i) disable iff (rst_i) job_end_i |-> busy_o);

endmodule : gemm_apb_regs

`default_nettype wire

/* hw/gemm_scratchpad.sv */
// Word scratchpad with an APB access port and a pipeline read/write port carrying op tags
`timescale 1ns/1ns
`default_nettype none
`include "gemm_defines.svh"

module gemm_scratchpad (
  input  wire                          clk_i,
  // Port A, APB window
  input  wire                          a_we_i,
  input  wire  [`GEMM_MEM_AW-1:0]      a_addr_i,
  input  wire  [`GEMM_WORD_W-1:0]      a_wdata_i,
  output logic [`GEMM_WORD_W-1:0]      a_rdata_o,
  // Port B, compute pipeline
  input  wire                          b_re_i,
  input  wire  [`GEMM_MEM_AW-1:0]      b_raddr_i,
  input  gemm_pkg::pipe_op_e           b_op_i,
  input  wire  [`GEMM_MEM_AW-1:0]      b_zaddr_i,
  output logic                         b_rvalid_o,
  output logic [`GEMM_WORD_W-1:0]      b_rdata_o,
  output gemm_pkg::pipe_op_e           b_op_o,
  output logic [`GEMM_MEM_AW-1:0]      b_zaddr_o,
  input  wire                          b_we_i,
  input  wire  [`GEMM_MEM_AW-1:0]      b_waddr_i,
  input  wire  [`GEMM_WORD_W-1:0]      b_wdata_i
);
  import gemm_pkg::*;

  logic [`GEMM_WORD_W-1:0] mem_q [`GEMM_MEM_DEPTH];

  assign a_rdata_o = mem_q[a_addr_i];

  always_ff @(posedge clk_i) begin
    if (a_we_i) begin
      mem_q[a_addr_i] <= a_wdata_i;
    end
    if (b_we_i) begin
      mem_q[b_waddr_i] <= b_wdata_i;
    end
  end

  // One-cycle read, tag and Z address follow the data
  always_ff @(posedge clk_i) begin
    b_rvalid_o <= b_re_i;
    b_rdata_o  <= mem_q[b_raddr_i];
    b_op_o     <= b_op_i;
    b_zaddr_o  <= b_zaddr_i;
  end

  // The window is closed while a job writes back results
  assert property (@(posedge clk_i) !(a_we_i && b_we_i && (a_addr_i == b_waddr_i)));

endmodule : gemm_scratchpad

`default_nettype wire

/* hw/gemm_streamer.sv */
// Fetch stage that walks rows and the K dimension, issuing one tagged scratchpad read per cycle
`timescale 1ns/1ns
`default_nettype none
`include "gemm_defines.svh"

module gemm_streamer (
  input  wire                          clk_i,
  input  wire                          rst_i,
  input  wire                          start_i,
  input  wire  [`GEMM_DIM_W-1:0]       m_i,
  input  wire  [`GEMM_DIM_W-1:0]       k_i,
  input  wire  [`GEMM_MEM_AW-1:0]      xbase_i,
  input  wire  [`GEMM_MEM_AW-1:0]      wbase_i,
  input  wire  [`GEMM_MEM_AW-1:0]      ybase_i,
  input  wire  [`GEMM_MEM_AW-1:0]      zbase_i,
  output logic                         rd_valid_o,
  output logic [`GEMM_MEM_AW-1:0]      rd_addr_o,
  output gemm_pkg::pipe_op_e           rd_op_o,
  output logic [`GEMM_MEM_AW-1:0]      zaddr_o,
  output logic                         job_end_o
);
  import gemm_pkg::*;

  fetch_state_e            state_q;
  logic [`GEMM_DIM_W-1:0]  row_q;
  logic [`GEMM_DIM_W-1:0]  kc_q;
  logic [`GEMM_DIM_W-1:0]  m_q;
  logic [`GEMM_DIM_W-1:0]  k_q;
  logic [`GEMM_MEM_AW-1:0] wbase_q;
  logic [`GEMM_MEM_AW-1:0] x_ptr_q;
  logic [`GEMM_MEM_AW-1:0] y_ptr_q;
  logic [`GEMM_MEM_AW-1:0] z_ptr_q;
  logic [`GEMM_MEM_AW-1:0] kc_ext;
  logic                    last_k;
  logic                    last_row;
  logic                    last_store;
  logic [2:0]              end_sr_q;

  assign kc_ext     = {{(`GEMM_MEM_AW-`GEMM_DIM_W){1'b0}}, kc_q};
  assign last_k     = (kc_q == k_q - `GEMM_DIM_W'(1));
  assign last_row   = (row_q == m_q - `GEMM_DIM_W'(1));
  assign last_store = (state_q == F_STORE) && last_row;

  // X rows are contiguous, so the X pointer simply runs through the job
  always_comb begin
    rd_valid_o = (state_q != F_IDLE);
    rd_op_o    = OP_LOAD_Y;
    rd_addr_o  = y_ptr_q;
    case (state_q)
      F_X: begin
        rd_op_o   = OP_LOAD_X;
        rd_addr_o = x_ptr_q;
      end
      F_W: begin
        rd_op_o   = OP_MAC_W;
        rd_addr_o = wbase_q + kc_ext;
      end
      F_STORE: begin
        rd_op_o   = OP_STORE;
        rd_addr_o = z_ptr_q;
      end
      default: ;
    endcase
  end

  assign zaddr_o = z_ptr_q;

  // Job end lines up with the write of the last Z row
  assign job_end_o = end_sr_q[2];

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q  <= F_IDLE;
      row_q    <= '0;
      kc_q     <= '0;
      end_sr_q <= '0;
    end else begin
      end_sr_q <= {end_sr_q[1:0], last_store};
      case (state_q)
        F_IDLE: begin
          if (start_i) begin
            state_q <= F_Y;
            row_q   <= '0;
            kc_q    <= '0;
          end
        end
        F_Y: state_q <= F_X;
        F_X: state_q <= F_W;
        F_W: begin
          if (last_k) begin
            kc_q    <= '0;
            state_q <= F_STORE;
          end else begin
            kc_q    <= kc_q + `GEMM_DIM_W'(1);
            state_q <= F_X;
          end
        end
        F_STORE: begin
          row_q   <= row_q + `GEMM_DIM_W'(1);
          state_q <= last_row ? F_IDLE : F_Y;
        end
        default: state_q <= F_IDLE;
      endcase
    end
  end

  // Job snapshot and address pointers
  always_ff @(posedge clk_i) begin
    if (state_q == F_IDLE && start_i) begin
      m_q     <= m_i;
      k_q     <= k_i;
      wbase_q <= wbase_i;
      x_ptr_q <= xbase_i;
      y_ptr_q <= ybase_i;
      z_ptr_q <= zbase_i;
    end else begin
      if (state_q == F_X) begin
        x_ptr_q <= x_ptr_q + `GEMM_MEM_AW'(1);
      end
      if (state_q == F_STORE) begin
        y_ptr_q <= y_ptr_q + `GEMM_MEM_AW'(1);
        z_ptr_q <= z_ptr_q + `GEMM_MEM_AW'(1);
      end
    end
  end

endmodule : gemm_streamer

`default_nettype wire

/* hw/gemm_engine.sv */
// Operand capture, multiply-accumulate and write-back stages producing one Z row per STORE
`timescale 1ns/1ns
`default_nettype none
`include "gemm_defines.svh"

module gemm_engine (
  input  wire                          clk_i,
  input  wire                          rst_i,
  input  wire                          in_valid_i,
  input  gemm_pkg::pipe_op_e           in_op_i,
  input  wire  [`GEMM_WORD_W-1:0]      in_data_i,
  input  wire  [`GEMM_MEM_AW-1:0]      in_zaddr_i,
  output logic                         wr_valid_o,
  output logic [`GEMM_MEM_AW-1:0]      wr_addr_o,
  output logic [`GEMM_WORD_W-1:0]      wr_data_o
);
  import gemm_pkg::*;

  // Stage 1
  logic                    s1_valid_q;
  pipe_op_e                s1_op_q;
  logic [`GEMM_WORD_W-1:0] s1_data_q;
  logic [`GEMM_MEM_AW-1:0] s1_zaddr_q;

  // Stage 2
  logic signed [`GEMM_ELEM_W-1:0]                         x_q;
  logic        [`GEMM_ARRAY_WIDTH-1:0][`GEMM_ELEM_W-1:0]  acc_q;
  logic        [`GEMM_ARRAY_WIDTH-1:0][`GEMM_ELEM_W-1:0]  mac_sum;
  logic signed [2*`GEMM_ELEM_W-1:0]                       prod [`GEMM_ARRAY_WIDTH];
  logic                                                   x_seen_q;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      s1_valid_q <= 1'b0;
    end else begin
      s1_valid_q <= in_valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    s1_op_q    <= in_op_i;
    s1_data_q  <= in_data_i;
    s1_zaddr_q <= in_zaddr_i;
  end

  // Lane i of a W row sits in bits [16i+15:16i], results wrap at 16 bits
  always_comb begin
    for (int i = 0; i < `GEMM_ARRAY_WIDTH; i++) begin
      prod[i]    = x_q * $signed(s1_data_q[i*`GEMM_ELEM_W +: `GEMM_ELEM_W]);
      mac_sum[i] = acc_q[i] + prod[i][`GEMM_ELEM_W-1:0];
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      wr_valid_o <= 1'b0;
      x_seen_q   <= 1'b0;
    end else begin
      wr_valid_o <= s1_valid_q && (s1_op_q == OP_STORE);
      if (s1_valid_q && s1_op_q == OP_LOAD_Y) begin
        x_seen_q <= 1'b0;
      end else if (s1_valid_q && s1_op_q == OP_LOAD_X) begin
        x_seen_q <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (s1_valid_q) begin
      case (s1_op_q)
        OP_LOAD_Y: acc_q <= s1_data_q;
        OP_LOAD_X: x_q   <= s1_data_q[`GEMM_ELEM_W-1:0];
        OP_MAC_W:  acc_q <= mac_sum;
        OP_STORE: begin
          wr_addr_o <= s1_zaddr_q;
          wr_data_o <= acc_q;
        end
        default: ;
      endcase
    end
  end

  // Fetch order guarantees an X element is held before any W row of the same output row
  assert property (@(posedge clk_i) disable iff (rst_i)
    (s1_valid_q && s1_op_q == OP_MAC_W) |-> x_seen_q);

endmodule : gemm_engine

`default_nettype wire

/* hw/gemm_top.sv */
// Top level of the GEMM accelerator, APB register file feeding the fetch, memory and MAC stages
`timescale 1ns/1ns
`default_nettype none
`include "gemm_defines.svh"

module gemm_top (
  input  wire                          clk_i,
  input  wire                          rst_i,
  input  wire                          psel_i,
  input  wire                          penable_i,
  input  wire                          pwrite_i,
  input  wire  [`GEMM_APB_AW-1:0]      paddr_i,
  input  wire  [`GEMM_WORD_W-1:0]      pwdata_i,
  output logic [`GEMM_WORD_W-1:0]      prdata_o,
  output logic                         pready_o,
  output logic                         pslverr_o,
  output logic                         busy_o,
  output logic                         done_o
);
  import gemm_pkg::*;

  // Job configuration
  logic                    start;
  logic                    job_end;
  logic [`GEMM_DIM_W-1:0]  m;
  logic [`GEMM_DIM_W-1:0]  k;
  logic [`GEMM_MEM_AW-1:0] xbase;
  logic [`GEMM_MEM_AW-1:0] wbase;
  logic [`GEMM_MEM_AW-1:0] ybase;
  logic [`GEMM_MEM_AW-1:0] zbase;

  // APB window into the scratchpad
  logic                    win_we;
  logic [`GEMM_MEM_AW-1:0] win_addr;
  logic [`GEMM_WORD_W-1:0] win_wdata;
  logic [`GEMM_WORD_W-1:0] win_rdata;

  // Pipeline read request and response
  logic                    rd_valid;
  logic [`GEMM_MEM_AW-1:0] rd_addr;
  pipe_op_e                rd_op;
  logic [`GEMM_MEM_AW-1:0] rd_zaddr;
  logic                    rsp_valid;
  logic [`GEMM_WORD_W-1:0] rsp_data;
  pipe_op_e                rsp_op;
  logic [`GEMM_MEM_AW-1:0] rsp_zaddr;

  // Z write-back
  logic                    wr_valid;
  logic [`GEMM_MEM_AW-1:0] wr_addr;
  logic [`GEMM_WORD_W-1:0] wr_data;

  gemm_apb_regs i_regs (
    .clk_i       ( clk_i     ),
    .rst_i       ( rst_i     ),
    .psel_i      ( psel_i    ),
    .penable_i   ( penable_i ),
    .pwrite_i    ( pwrite_i  ),
    .paddr_i     ( paddr_i   ),
    .pwdata_i    ( pwdata_i  ),
    .prdata_o    ( prdata_o  ),
    .pready_o    ( pready_o  ),
    .pslverr_o   ( pslverr_o ),
    .job_end_i   ( job_end   ),
    .start_o     ( start     ),
    .m_o         ( m         ),
    .k_o         ( k         ),
    .xbase_o     ( xbase     ),
    .wbase_o     ( wbase     ),
    .ybase_o     ( ybase     ),
    .zbase_o     ( zbase     ),
    .busy_o      ( busy_o    ),
    .done_o      ( done_o    ),
    .mem_we_o    ( win_we    ),
    .mem_addr_o  ( win_addr  ),
    .mem_wdata_o ( win_wdata ),
    .mem_rdata_i ( win_rdata )
  );

  gemm_streamer i_streamer (
    .clk_i      ( clk_i    ),
    .rst_i      ( rst_i    ),
    .start_i    ( start    ),
    .m_i        ( m        ),
    .k_i        ( k        ),
    .xbase_i    ( xbase    ),
    .wbase_i    ( wbase    ),
    .ybase_i    ( ybase    ),
    .zbase_i    ( zbase    ),
    .rd_valid_o ( rd_valid ),
    .rd_addr_o  ( rd_addr  ),
    .rd_op_o    ( rd_op    ),
    .zaddr_o    ( rd_zaddr ),
    .job_end_o  ( job_end  )
  );

  gemm_scratchpad i_scratchpad (
    .clk_i      ( clk_i     ),
    .a_we_i     ( win_we    ),
    .a_addr_i   ( win_addr  ),
    .a_wdata_i  ( win_wdata ),
    .a_rdata_o  ( win_rdata ),
    .b_re_i     ( rd_valid  ),
    .b_raddr_i  ( rd_addr   ),
    .b_op_i     ( rd_op     ),
    .b_zaddr_i  ( rd_zaddr  ),
    .b_rvalid_o ( rsp_valid ),
    .b_rdata_o  ( rsp_data  ),
    .b_op_o     ( rsp_op    ),
    .b_zaddr_o  ( rsp_zaddr ),
    .b_we_i     ( wr_valid  ),
    .b_waddr_i  ( wr_addr   ),
    .b_wdata_i  ( wr_data   )
  );

  gemm_engine i_engine (
    .clk_i      ( clk_i     ),
    .rst_i      ( rst_i     ),
    .in_valid_i ( rsp_valid ),
    .in_op_i    ( rsp_op    ),
    .in_data_i  ( rsp_data  ),
    .in_zaddr_i ( rsp_zaddr ),
    .wr_valid_o ( wr_valid  ),
    .wr_addr_o  ( wr_addr   ),
    .wr_data_o  ( wr_data   )
  );

endmodule : gemm_top

`default_nettype wire

/* verif/gemm_tb.sv */
// Testbench that replays the command file verif/gemm_stim.txt over APB against the GEMM top level
`timescale 1ns/1ns
`default_nettype none

module gemm_tb;

  localparam logic [11:0] reg_m_addr     = 12'h008;
  localparam logic [11:0] reg_k_addr     = 12'h00C;
  // Longest possible job has M = K = 15
  localparam int          job_max_cycles = 15 * 32 + 3;

  logic        clk;
  logic        rst;
  logic        psel;
  logic        penable;
  logic        pwrite;
  logic [11:0] paddr;
  logic [31:0] pwdata;
  logic [31:0] prdata;
  logic        pready;
  logic        pslverr;
  logic        busy;
  logic        done;

  // Commands parsed from the stimulus file
  logic [7:0]  cmd_q [$];
  logic [11:0] addr_q [$];
  logic [31:0] data_q [$];
  string       name_q [$];

  int unsigned cycle_cnt = 0;
  int unsigned timeout_cycles = 1000;
  int unsigned start_cycle = 0;
  logic [31:0] m_shadow = 32'd0;
  logic [31:0] k_shadow = 32'd0;
  logic [31:0] expected_latency = 32'd0;

  gemm_top gemm_top_inst (
    .clk_i     ( clk     ),
    .rst_i     ( rst     ),
    .psel_i    ( psel    ),
    .penable_i ( penable ),
    .pwrite_i  ( pwrite  ),
    .paddr_i   ( paddr   ),
    .pwdata_i  ( pwdata  ),
    .prdata_o  ( prdata  ),
    .pready_o  ( pready  ),
    .pslverr_o ( pslverr ),
    .busy_o    ( busy    ),
    .done_o    ( done    )
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= timeout_cycles) begin
      $display("Timeout: the run did not finish within %0d cycles", timeout_cycles);
      stop_on_failure();
    end
  end

  task automatic stop_on_failure();
    $display("Checks failed");
    $fatal(1, "Simulation stopped at the first failure");
  endtask

  task automatic check_value(input string test_name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (actual !== expected) begin
      $display("CHECK FAILED %s: expected %08h, actual %08h", test_name, expected, actual);
      stop_on_failure();
    end
  endtask

  // Runs the setup and access phases and returns just after the idle edge
  task automatic apb_transfer(input string test_name, input logic wr, input logic [11:0] addr,
                              input logic [31:0] wdata, output logic [31:0] rdata,
                              output logic err);
    @(negedge clk);
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = wr;
    paddr   = addr;
    pwdata  = wdata;
    @(negedge clk);
    penable = 1'b1;
    #1;
    check_value({test_name, ":pready"}, 32'd1, {31'd0, pready});
    rdata = prdata;
    err   = pslverr;
    @(negedge clk);
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
    #1;
  endtask

  // Busy must hold until the done pulse that comes M*(2K+2)+3 cycles after the start
  task automatic wait_for_done(input string test_name);
    while (done !== 1'b1) begin
      check_value({test_name, ":busy"}, 32'd1, {31'd0, busy});
      @(negedge clk);
      #1;
    end
    check_value({test_name, ":latency"}, expected_latency, cycle_cnt - start_cycle);
    @(negedge clk);
    #1;
    check_value({test_name, ":busy_after"}, 32'd0, {31'd0, busy});
    check_value({test_name, ":done_pulse"}, 32'd0, {31'd0, done});
  endtask

  task automatic start_job(input string test_name, input logic [11:0] addr,
                           input logic [31:0] data);
    logic [31:0] rdata;
    logic        err;
    apb_transfer(test_name, 1'b1, addr, data, rdata, err);
    check_value({test_name, ":pslverr"}, 32'd0, {31'd0, err});
    // Start was taken in the access phase one cycle back
    start_cycle      = cycle_cnt - 1;
    expected_latency = m_shadow * (32'd2 * k_shadow + 32'd2) + 32'd3;
    check_value({test_name, ":busy_start"}, 32'd1, {31'd0, busy});
  endtask

  task automatic run_command(input logic [7:0] cmd, input logic [11:0] addr,
                             input logic [31:0] data, input string test_name);
    logic [31:0] rdata;
    logic        err;
    case (cmd)
      "W": begin
        apb_transfer(test_name, 1'b1, addr, data, rdata, err);
        check_value({test_name, ":pslverr"}, 32'd0, {31'd0, err});
        if (addr == reg_m_addr) m_shadow = {28'd0, data[3:0]};
        if (addr == reg_k_addr) k_shadow = {28'd0, data[3:0]};
      end
      "R": begin
        apb_transfer(test_name, 1'b0, addr, 32'd0, rdata, err);
        check_value({test_name, ":pslverr"}, 32'd0, {31'd0, err});
        check_value(test_name, data, rdata);
      end
      "E": begin
        apb_transfer(test_name, 1'b1, addr, data, rdata, err);
        check_value({test_name, ":pslverr"}, 32'd1, {31'd0, err});
      end
      "F": begin
        apb_transfer(test_name, 1'b0, addr, 32'd0, rdata, err);
        check_value({test_name, ":pslverr"}, 32'd1, {31'd0, err});
        check_value(test_name, 32'd0, rdata);
      end
      "G": start_job(test_name, addr, data);
      "D": wait_for_done(test_name);
      "S": begin
        start_job(test_name, addr, data);
        wait_for_done(test_name);
      end
      default: begin
        $display("Unknown command %c in the stimulus file", cmd);
        stop_on_failure();
      end
    endcase
  endtask

  task automatic load_stimulus();
    int          fd;
    int          code;
    string       line;
    logic [7:0]  cmd;
    logic [11:0] addr;
    logic [31:0] data;
    string       test_name;
    fd = $fopen("verif/gemm_stim.txt", "r");
    if (fd == 0) begin
      $display("Could not open verif/gemm_stim.txt for reading");
      stop_on_failure();
    end else begin
      while (!$feof(fd)) begin
        if ($fgets(line, fd) > 0) begin
          code = $sscanf(line, "%c %h %h %s", cmd, addr, data, test_name);
          // Lines opening with # describe the columns
          if (code == 4 && cmd != "#") begin
            cmd_q.push_back(cmd);
            addr_q.push_back(addr);
            data_q.push_back(data);
            name_q.push_back(test_name);
          end
        end
      end
      $fclose(fd);
      timeout_cycles = cmd_q.size() * job_max_cycles + 1000;
    end
  endtask

  initial begin
    rst     = 1'b1;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
    paddr   = 12'h000;
    pwdata  = 32'd0;
    load_stimulus();
    repeat (3) @(negedge clk);
    rst = 1'b0;
    #1;
    check_value("reset:busy", 32'd0, {31'd0, busy});
    check_value("reset:done", 32'd0, {31'd0, done});
    for (int i = 0; i < cmd_q.size(); i++) begin
      run_command(cmd_q[i], addr_q[i], data_q[i], name_q[i]);
    end
    if (cmd_q.size() > 0) begin
      $display("All checks passed");
      $finish;
    end else begin
      $display("The stimulus file held no commands");
      stop_on_failure();
    end
  end

endmodule : gemm_tb

`default_nettype wire

/* gemm_top.f */
+incdir+include
hw/gemm_pkg.sv
hw/gemm_apb_regs.sv
hw/gemm_scratchpad.sv
hw/gemm_streamer.sv
hw/gemm_engine.sv
hw/gemm_top.sv
verif/gemm_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Builds the GEMM testbench with Verilator, runs it and checks the log
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module gemm_tb -f gemm_top.f

# The testbench stops with $fatal on a failure, so the log decides the result
./obj_dir/Vgemm_tb > sim.log 2>&1 || true
cat sim.log

if grep -q "Checks failed" sim.log; then
  echo "Simulation FAILED"
  exit 1
fi
if ! grep -q "All checks passed" sim.log; then
  echo "Simulation ended without a result"
  exit 1
fi
echo "Simulation PASSED"

/* verif/gemm_stim.txt */
# Columns: command, APB byte address, write data or expected value, test name
# W write, R read and compare, E write with error, F read with error, G start, D wait, S start+wait
R 004 00000000 status_after_reset
W 400 00000003 x_1x1
W 440 FFFE0005 w_1x1
W 480 000A0007 y_1x1
W 008 00000001 m_1x1
W 00C 00000001 k_1x1
W 010 00000000 xbase_1x1
W 014 00000010 wbase_1x1
W 018 00000020 ybase_1x1
W 01C 00000030 zbase_1x1
R 008 00000001 m_readback
R 00C 00000001 k_readback
R 010 00000000 xbase_readback
R 014 00000010 wbase_readback
R 018 00000020 ybase_readback
R 01C 00000030 zbase_readback
S 000 00000001 job_1x1
R 004 00000002 status_done_1x1
R 4C0 00040016 z_1x1
W 404 00004000 x_wrap
W 444 7FFF0005 w_wrap
W 010 00000001 xbase_wrap
W 014 00000011 wbase_wrap
W 018 00000030 ybase_wrap
W 01C 00000031 zbase_wrap
S 000 00000001 job_wrap
R 4C4 C0044016 z_wrap
R 4C0 00040016 z_1x1_kept
W 500 00000001 x_r0_k0
W 504 0000FFFE x_r0_k1
W 508 00000003 x_r0_k2
W 50C 0000FFFC x_r0_k3
W 510 00000005 x_r1_k0
W 514 00000000 x_r1_k1
W 518 0000FFFF x_r1_k2
W 51C 00000002 x_r1_k3
W 520 0000FFFD x_r2_k0
W 524 00000004 x_r2_k1
W 528 00000002 x_r2_k2
W 52C 0000FFFF x_r2_k3
W 540 FFFF0002 w_k0
W 544 00040003 w_k1
W 548 0001FFFB w_k2
W 54C FFFE0001 w_k3
W 560 FFF6000A y_r0
W 564 00640000 y_r1
W 568 0007FFF9 y_r2
W 008 00000003 m_3x4
W 00C 00000004 k_3x4
W 010 00000040 xbase_3x4
W 014 00000050 wbase_3x4
W 018 00000058 ybase_3x4
W 01C 00000060 zbase_3x4
G 000 00000001 job_3x4_start
R 004 00000001 status_busy
E 440 DEADBEEF window_write_busy
F 440 00000000 window_read_busy
E 000 00000001 start_while_busy
D 000 00000000 job_3x4_done
R 004 00000002 status_done_3x4
R 440 FFFE0005 window_write_blocked
R 580 FFF8FFF3 z_3x4_r0
R 584 005A0011 z_3x4_r1
R 588 001EFFF4 z_3x4_r2
W 00C 00000000 k_zero
R 00C 00000000 k_zero_readback
E 000 00000001 start_k_zero
R 004 00000002 status_kept_k_zero
E 020 00000001 unmapped_write
F 800 00000000 unmapped_read
R 004 00000002 status_final
